// File: src/memBusPkg.sv
package memBusPkg;

    // byte address into the shared RAM
    localparam int addrWidth = 17;

    // data and instruction word width
    localparam int dataWidth = 32;

    // width of one RAM location
    localparam int byteWidth = 8;

    // bytes in one full word and in every fetch
    localparam int wordBytes = 4;

endpackage

// File: src/memOpPkg.sv
package memOpPkg;

    // direction of an access
    typedef enum logic {
        dirRead  = 1'b0,
        dirWrite = 1'b1
    } accessDir;

    // requesting port of an access
    typedef enum logic {
        portInst = 1'b0,
        portLs   = 1'b1
    } portSel;

    // byte count of an access
    typedef logic [2:0] accessLen;

    localparam accessLen lenByte = 3'd1;
    localparam accessLen lenHalf = 3'd2;
    localparam accessLen lenWord = 3'd4;

endpackage

// File: src/byteRam.sv
`timescale 1ns/1ps

module byteRam import memBusPkg::*; #(
    parameter int ramDepthLog2 = 17
) (
    input  logic                 clk,
    input  logic                 rdy,
    input  logic                 we,
    input  logic [addrWidth-1:0] addr,
    input  logic [byteWidth-1:0] wdata,
    output logic [byteWidth-1:0] rdata
);

    localparam int ramDepth = 1 << ramDepthLog2;

    logic [byteWidth-1:0] mem [0:ramDepth-1];
    logic [ramDepthLog2-1:0] index;

    // upper address bits lie outside the array
    assign index = addr[ramDepthLog2-1:0];

    // registered read that returns old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (we) begin
                mem[index] <= wdata;
            end
            rdata <= mem[index];
        end
    end

endmodule

// File: src/memArbiter.sv
`timescale 1ns/1ps

module memArbiter import memBusPkg::*, memOpPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 missEn,
    input  logic [addrWidth-1:0] missAddr,
    input  logic                 missCancel,
    output logic                 missDone,
    output logic [dataWidth-1:0] missData,
    input  logic                 lsEn,
    input  accessDir             lsDir,
    input  logic [addrWidth-1:0] lsAddr,
    input  accessLen             lsLen,
    input  logic [dataWidth-1:0] storeData,
    output logic                 lsDone,
    output logic [dataWidth-1:0] loadData,
    output logic                 ramWe,
    output logic [addrWidth-1:0] ramAddr,
    output logic [byteWidth-1:0] ramWdata,
    input  logic [byteWidth-1:0] ramRdata
);

    localparam int shiftBits = $clog2(dataWidth);

    // one waiting slot per port
    logic                 lsWait;
    accessDir             lsWaitDir;
    logic [addrWidth-1:0] lsWaitAddr;
    accessLen             lsWaitLen;
    logic [dataWidth-1:0] lsWaitData;
    logic                 instWait;
    logic [addrWidth-1:0] instWaitAddr;

    // access in flight
    logic                 busy;
    portSel               curPort;
    accessDir             curDir;
    accessLen             curLen;
    accessLen             stage;
    logic [addrWidth-1:0] curAddr;
    logic [dataWidth-1:0] storeShift;
    logic [dataWidth-1:0] captureReg;
    logic [dataWidth-1:0] loadHold;

    // choice of the next access
    logic                 takeLsSlot;
    logic                 takeInstSlot;
    logic                 takeLsNew;
    logic                 takeInstNew;
    logic                 startAny;
    portSel               nxtPort;
    accessDir             nxtDir;
    logic [addrWidth-1:0] nxtAddr;
    accessLen             nxtLen;
    logic [dataWidth-1:0] nxtData;

    logic                 lastStage;
    logic                 finishing;
    logic                 canStart;
    logic [shiftBits-1:0] byteShift;
    logic [dataWidth-1:0] merged;

    assign lastStage = busy && stage == curLen;
    // a cancelled fetch ends right away
    assign finishing = lastStage || (busy && curPort == portInst && missCancel);
    assign canStart = !busy || finishing;

    // byte read at stage s-1 arrives at stage s
    assign byteShift = shiftBits'((stage - 3'd1) * byteWidth);
    assign merged = captureReg | (dataWidth'(ramRdata) << byteShift);

    // LS slot, fetch slot, new LS, new fetch
    always_comb begin
        takeLsSlot = 1'b0;
        takeInstSlot = 1'b0;
        takeLsNew = 1'b0;
        takeInstNew = 1'b0;
        nxtPort = portLs;
        nxtDir = lsDir;
        nxtAddr = lsAddr;
        nxtLen = lsLen;
        nxtData = storeData;
        if (lsWait) begin
            takeLsSlot = canStart;
            nxtDir = lsWaitDir;
            nxtAddr = lsWaitAddr;
            nxtLen = lsWaitLen;
            nxtData = lsWaitData;
        end else if (instWait && !missCancel) begin
            takeInstSlot = canStart;
            nxtPort = portInst;
            nxtDir = dirRead;
            nxtAddr = instWaitAddr;
            nxtLen = lenWord;
        end else if (lsEn) begin
            takeLsNew = canStart;
        end else if (missEn && !missCancel) begin
            takeInstNew = canStart;
            nxtPort = portInst;
            nxtDir = dirRead;
            nxtAddr = missAddr;
            nxtLen = lenWord;
        end
    end

    assign startAny = takeLsSlot || takeInstSlot || takeLsNew || takeInstNew;

    assign ramWe = busy && curDir == dirWrite && stage < curLen;
    assign ramAddr = curAddr;
    assign ramWdata = storeShift[byteWidth-1:0];

    assign lsDone = rdy && lastStage && curPort == portLs;
    assign missDone = rdy && lastStage && curPort == portInst && !missCancel;
    assign missData = merged;
    // last byte comes straight from the RAM in the done cycle
    assign loadData = (lsDone && curDir == dirRead) ? merged : loadHold;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            stage <= '0;
            curPort <= portInst;
            curDir <= dirRead;
            curLen <= '0;
            lsWait <= 1'b0;
            instWait <= 1'b0;
        end else if (rdy) begin
            if (takeLsSlot) begin
                lsWait <= 1'b0;
            end else if (lsEn && !takeLsNew) begin
                lsWait <= 1'b1;
            end
            if (missCancel || takeInstSlot) begin
                instWait <= 1'b0;
            end else if (missEn && !takeInstNew) begin
                instWait <= 1'b1;
            end
            if (canStart) begin
                busy <= startAny;
                stage <= '0;
                curPort <= nxtPort;
                curDir <= nxtDir;
                curLen <= nxtLen;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (lsEn) begin
                lsWaitDir <= lsDir;
                lsWaitAddr <= lsAddr;
                lsWaitLen <= lsLen;
                lsWaitData <= storeData;
            end
            if (missEn) begin
                instWaitAddr <= missAddr;
            end
            if (canStart) begin
                curAddr <= nxtAddr;
                storeShift <= nxtData;
                captureReg <= '0;
            end else begin
                curAddr <= curAddr + 1'b1;
                storeShift <= storeShift >> byteWidth;
                if (stage != '0) begin
                    captureReg <= merged;
                end
            end
            if (lsDone && curDir == dirRead) begin
                loadHold <= merged;
            end
        end
    end

endmodule

// File: src/instCache.sv
`timescale 1ns/1ps

module instCache import memBusPkg::*; #(
    parameter int cacheIndexBits = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 fetchEn,
    input  logic [addrWidth-1:0] pc,
    input  logic                 flush,
    output logic                 instValid,
    output logic [dataWidth-1:0] inst,
    output logic [addrWidth-1:0] instPc,
    output logic                 missEn,
    output logic [addrWidth-1:0] missAddr,
    output logic                 missCancel,
    input  logic                 missDone,
    input  logic [dataWidth-1:0] missData
);

    localparam int offsetBits = $clog2(wordBytes);
    localparam int tagBits = addrWidth - cacheIndexBits - offsetBits;
    localparam int lineCount = 1 << cacheIndexBits;

    logic [lineCount-1:0] lineValid;
    logic [tagBits-1:0]   lineTag [0:lineCount-1];
    logic [dataWidth-1:0] lineData [0:lineCount-1];

    logic [cacheIndexBits-1:0] fetchIdx;
    logic [tagBits-1:0]        fetchTag;
    logic                      hit;

    // the one outstanding miss
    logic                      pendValid;
    logic [addrWidth-1:0]      pendPc;
    logic [cacheIndexBits-1:0] pendIdx;
    logic [tagBits-1:0]        pendTag;
    logic                      fill;

    assign fetchIdx = pc[offsetBits +: cacheIndexBits];
    assign fetchTag = pc[addrWidth-1 -: tagBits];
    assign hit = lineValid[fetchIdx] && lineTag[fetchIdx] == fetchTag;

    assign pendIdx = pendPc[offsetBits +: cacheIndexBits];
    assign pendTag = pendPc[addrWidth-1 -: tagBits];
    // a flush in the done cycle already suppresses missDone
    assign fill = pendValid && missDone && !flush;

    assign missEn = fetchEn && !hit && !flush;
    assign missAddr = pc;
    assign missCancel = flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            lineValid <= '0;
            pendValid <= 1'b0;
            instValid <= 1'b0;
        end else if (rdy) begin
            instValid <= 1'b0;
            if (flush) begin
                pendValid <= 1'b0;
            end else if (fill) begin
                lineValid[pendIdx] <= 1'b1;
                pendValid <= 1'b0;
                instValid <= 1'b1;
            end else if (fetchEn) begin
                if (hit) begin
                    instValid <= 1'b1;
                end else begin
                    pendValid <= 1'b1;
                end
            end
        end
    end

    // tags, words and the output word
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (fill) begin
                lineTag[pendIdx] <= pendTag;
                lineData[pendIdx] <= missData;
                inst <= missData;
                instPc <= pendPc;
            end else if (fetchEn && !flush) begin
                if (hit) begin
                    inst <= lineData[fetchIdx];
                    instPc <= pc;
                end else begin
                    pendPc <= pc;
                end
            end
        end
    end

endmodule

// File: src/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem import memBusPkg::*, memOpPkg::*; #(
    parameter int ramDepthLog2 = 17,
    parameter int cacheIndexBits = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 fetchEn,
    input  logic [addrWidth-1:0] pc,
    input  logic                 flush,
    output logic                 instValid,
    output logic [dataWidth-1:0] inst,
    output logic [addrWidth-1:0] instPc,
    input  logic                 lsEn,
    input  accessDir             lsDir,
    input  logic [addrWidth-1:0] lsAddr,
    input  accessLen             lsLen,
    input  logic [dataWidth-1:0] storeData,
    output logic                 lsDone,
    output logic [dataWidth-1:0] loadData
);

    // cache miss path
    logic                 missEn;
    logic [addrWidth-1:0] missAddr;
    logic                 missCancel;
    logic                 missDone;
    logic [dataWidth-1:0] missData;

    // RAM port
    logic                 ramWe;
    logic [addrWidth-1:0] ramAddr;
    logic [byteWidth-1:0] ramWdata;
    logic [byteWidth-1:0] ramRdata;

    instCache #(
        .cacheIndexBits(cacheIndexBits)
    ) cache0 (
        .clk(clk), .rst(rst), .rdy(rdy),
        .fetchEn(fetchEn), .pc(pc), .flush(flush),
        .instValid(instValid), .inst(inst), .instPc(instPc),
        .missEn(missEn), .missAddr(missAddr), .missCancel(missCancel),
        .missDone(missDone), .missData(missData)
    );

    memArbiter arbiter0 (
        .clk(clk), .rst(rst), .rdy(rdy),
        .missEn(missEn), .missAddr(missAddr), .missCancel(missCancel),
        .missDone(missDone), .missData(missData),
        .lsEn(lsEn), .lsDir(lsDir), .lsAddr(lsAddr), .lsLen(lsLen),
        .storeData(storeData), .lsDone(lsDone), .loadData(loadData),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    byteRam #(
        .ramDepthLog2(ramDepthLog2)
    ) ram0 (
        .clk(clk), .rdy(rdy), .we(ramWe),
        .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
    );

endmodule

// File: tests/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb import memBusPkg::*, memOpPkg::*; ();

    localparam int wordCount = 8;
    // requests of tests 1 to 6 in order
    localparam int requestCount = 2 * wordCount + 16 + 12 + 4 + 3 + 2 * wordCount;
    localparam int cycleLimit = requestCount * 60 + 100;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 fetchEn;
    logic [addrWidth-1:0] pc;
    logic                 flush;
    logic                 instValid;
    logic [dataWidth-1:0] inst;
    logic [addrWidth-1:0] instPc;
    logic                 lsEn;
    accessDir             lsDir;
    logic [addrWidth-1:0] lsAddr;
    accessLen             lsLen;
    logic [dataWidth-1:0] storeData;
    logic                 lsDone;
    logic [dataWidth-1:0] loadData;

    // byte image of the RAM as the tests wrote it
    logic [byteWidth-1:0] shadow [0:(1 << addrWidth)-1];
    logic [dataWidth-1:0] lsExpQ [$];
    logic                 lsLoadQ [$];
    logic [dataWidth-1:0] instExpQ [$];
    logic [addrWidth-1:0] instPcQ [$];
    logic [dataWidth-1:0] lsExpWord;
    logic                 lsExpLoad;
    logic [31:0]          rngState = 32'h48bf;
    logic [31:0]          stallState = 32'h48bf;
    logic                 stallOn = 1'b0;
    int                   errors = 0;
    int                   checks = 0;
    int                   passed = 0;
    int                   failed = 0;
    int                   cycleCount = 0;

    memSubsystem #(
        .ramDepthLog2(17),
        .cacheIndexBits(4)
    ) dut0 (
        .clk(clk), .rst(rst), .rdy(rdy),
        .fetchEn(fetchEn), .pc(pc), .flush(flush),
        .instValid(instValid), .inst(inst), .instPc(instPc),
        .lsEn(lsEn), .lsDir(lsDir), .lsAddr(lsAddr), .lsLen(lsLen),
        .storeData(storeData), .lsDone(lsDone), .loadData(loadData)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // region picks the top two address bits
    function automatic logic [addrWidth-1:0] randWordAddr(input logic [1:0] region);
        logic [31:0] r;
        r = randWord();
        return {region, r[14:2], 2'b00};
    endfunction

    // little-endian read of the shadow with zero extension
    function automatic logic [dataWidth-1:0] refLoad(input logic [addrWidth-1:0] addr,
                                                     input accessLen len);
        logic [dataWidth-1:0] word;
        word = '0;
        for (int i = 0; i < wordBytes; i++) begin
            if (i < len) begin
                word[i*byteWidth +: byteWidth] = shadow[addr + i];
            end
        end
        return word;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        @(negedge clk);
        if (errors == errorsBefore) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    // lat counts edges with rdy high from acceptance to lsDone
    task automatic runLs(input accessDir dir, input logic [addrWidth-1:0] addr,
                         input accessLen len, input logic [dataWidth-1:0] data,
                         output int lat);
        @(negedge clk);
        lsEn = 1'b1;
        lsDir = dir;
        lsAddr = addr;
        lsLen = len;
        storeData = data;
        if (dir == dirWrite) begin
            for (int i = 0; i < len; i++) begin
                shadow[addr + i] = data[i*byteWidth +: byteWidth];
            end
        end
        lsExpQ.push_back(refLoad(addr, len));
        lsLoadQ.push_back(dir == dirRead);
        // request held until an edge with rdy high takes it
        do @(posedge clk); while (!rdy);
        @(negedge clk);
        lsEn = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            if (rdy) lat++;
        end while (!lsDone);
    endtask

    task automatic runFetch(input logic [addrWidth-1:0] addr, output int lat);
        @(negedge clk);
        fetchEn = 1'b1;
        pc = addr;
        instExpQ.push_back(refLoad(addr, lenWord));
        instPcQ.push_back(addr);
        do @(posedge clk); while (!rdy);
        @(negedge clk);
        fetchEn = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            if (rdy) lat++;
        end while (!(instValid && rdy));
    endtask

    task automatic wordRoundTrip();
        logic [addrWidth-1:0] addrs [wordCount];
        int lat;
        for (int i = 0; i < wordCount; i++) begin
            addrs[i] = randWordAddr(2'd0);
            runLs(dirWrite, addrs[i], lenWord, randWord(), lat);
            checkValue("lsDoneLatency", lat, 5);
        end
        for (int i = 0; i < wordCount; i++) begin
            runLs(dirRead, addrs[i], lenWord, '0, lat);
            checkValue("lsDoneLatency", lat, 5);
        end
    endtask

    // compare process for both done pulses
    always @(posedge clk) begin
        if (!rst && lsDone) begin
            if (lsExpQ.size() == 0) begin
                errors++;
                $display("lsDone pulsed with no load or store outstanding");
            end else begin
                lsExpWord = lsExpQ.pop_front();
                lsExpLoad = lsLoadQ.pop_front();
                if (lsExpLoad) begin
                    checkValue("loadData", loadData, lsExpWord);
                end
            end
        end
        if (!rst && rdy && instValid) begin
            if (instExpQ.size() == 0) begin
                errors++;
                $display("instValid pulsed with no fetch outstanding");
            end else begin
                checkValue("inst", inst, instExpQ.pop_front());
                checkValue("instPc", instPc, instPcQ.pop_front());
            end
        end
        if (!rdy && lsDone) begin
            errors++;
            $display("lsDone pulsed while rdy was low");
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("run timed out after %0d cycles waiting for a done pulse", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // random rdy stalls with 1 in 4 cycles low
    always @(negedge clk) begin
        if (stallOn) begin
            stallState = xorshift(stallState);
            rdy = stallState[2:1] != 2'b00;
        end else begin
            rdy = 1'b1;
        end
    end

    initial begin
        int lat;
        int mark;
        int lsAt;
        int instAt;
        logic [addrWidth-1:0] addrA;
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        fetchEn = 1'b0;
        pc = '0;
        flush = 1'b0;
        lsEn = 1'b0;
        lsDir = dirRead;
        lsAddr = '0;
        lsLen = lenWord;
        storeData = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        mark = errors;
        wordRoundTrip();
        finishTest("word store and load", mark);

        mark = errors;
        for (int i = 0; i < wordCount / 2; i++) begin
            addrA = randWordAddr(2'd1);
            runLs(dirWrite, addrA, lenWord, randWord(), lat);
            runLs(dirWrite, addrA + addrWidth'(randWord() & 32'd2), lenHalf, randWord(), lat);
            runLs(dirWrite, addrA + addrWidth'(randWord() & 32'd3), lenByte, randWord(), lat);
            runLs(dirRead, addrA, lenWord, '0, lat);
        end
        finishTest("byte and halfword merge", mark);

        // four words on distinct cache lines
        mark = errors;
        addrA = randWordAddr(2'd2) & ~addrWidth'(6'h3c);
        for (int i = 0; i < 4; i++) begin
            runLs(dirWrite, addrA + addrWidth'(4 * i), lenWord, randWord(), lat);
        end
        for (int i = 0; i < 4; i++) begin
            runFetch(addrA + addrWidth'(4 * i), lat);
            checkValue("fetchMiss", lat > 1, 1);
        end
        for (int i = 0; i < 4; i++) begin
            runFetch(addrA + addrWidth'(4 * i), lat);
            checkValue("hitLatency", lat, 1);
        end
        finishTest("fetch miss then hit", mark);

        mark = errors;
        addrA = randWordAddr(2'd3);
        runLs(dirWrite, addrA, lenWord, randWord(), lat);
        runLs(dirWrite, addrA ^ addrWidth'(12'h100), lenWord, randWord(), lat);
        @(negedge clk);
        fetchEn = 1'b1;
        pc = addrA;
        instExpQ.push_back(refLoad(addrA, lenWord));
        instPcQ.push_back(addrA);
        lsEn = 1'b1;
        lsDir = dirRead;
        lsAddr = addrA ^ addrWidth'(12'h100);
        lsLen = lenWord;
        lsExpQ.push_back(refLoad(lsAddr, lenWord));
        lsLoadQ.push_back(1'b1);
        @(negedge clk);
        fetchEn = 1'b0;
        lsEn = 1'b0;
        lsAt = 0;
        instAt = 0;
        for (int n = 1; lsAt == 0 || instAt == 0; n++) begin
            @(posedge clk);
            if (lsDone && lsAt == 0) lsAt = n;
            if (instValid && instAt == 0) instAt = n;
        end
        checkValue("lsDoneFirst", lsAt <= instAt, 1);
        finishTest("fetch and load together", mark);

        mark = errors;
        addrA = addrA ^ addrWidth'(12'h200);
        runLs(dirWrite, addrA, lenWord, randWord(), lat);
        @(negedge clk);
        fetchEn = 1'b1;
        pc = addrA;
        @(negedge clk);
        fetchEn = 1'b0;
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // the cancelled fetch must stay silent
        repeat (12) @(negedge clk);
        runFetch(addrA, lat);
        checkValue("refetchMiss", lat > 1, 1);
        finishTest("flush during miss", mark);

        mark = errors;
        @(posedge clk);
        stallOn = 1'b1;
        wordRoundTrip();
        stallOn = 1'b0;
        finishTest("word store and load with stalls", mark);

        if (lsExpQ.size() != 0 || instExpQ.size() != 0) begin
            errors++;
            $display("%0d load/store and %0d fetch results never arrived",
                     lsExpQ.size(), instExpQ.size());
        end
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: memSubsystem.f
src/memBusPkg.sv
src/memOpPkg.sv
src/byteRam.sv
src/memArbiter.sv
src/instCache.sv
src/memSubsystem.sv
tests/memSubsystemTb.sv
